// File: Makefile
# Verilator build and run for the memory subsystem

VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILE_LIST ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing
PASS_MSG  ?= Simulation passed

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
logic/mem_bus_pkg.sv
logic/mem_ctrl_pkg.sv
logic/mem_request_bridge.sv
logic/mem_controller_model.sv
logic/mem_subsystem_top.sv
testbench/mem_subsystem_chk.sv
testbench/mem_subsystem_tb.sv

// File: logic/mem_bus_pkg.sv
// Local memory port types
package mem_bus_pkg;

	localparam int WORD_W = 32;
	localparam int ADDR_W = 27;
	localparam int LAT_W  = 4;

	// one data word on both the requester side and the local port
	typedef logic [WORD_W-1:0] word_t;

	// word address on the local port
	typedef logic [ADDR_W-1:0] addr_t;

	// read latency and stall run counts
	typedef logic [LAT_W-1:0] lat_t;

endpackage

// File: logic/mem_controller_model.sv
// Local port memory controller model
`timescale 1ns/1ns

module mem_controller_model #(
	parameter int INIT_CYCLES    = 20,
	parameter int READ_LATENCY   = 4,
	parameter int MEM_DEPTH_LOG2 = 8
) (
	input  logic               i_clock,
	input  logic               i_arst_n,
	input  logic               i_avl_read_req,
	input  logic               i_avl_write_req,
	input  logic               i_avl_burstbegin,
	input  mem_bus_pkg::addr_t i_avl_addr,
	input  mem_bus_pkg::word_t i_avl_wdata,
	output logic               o_avl_ready,
	output logic               o_avl_rdata_valid,
	output mem_bus_pkg::word_t o_avl_rdata,
	output logic               o_local_init_done
);
	import mem_bus_pkg::*;
	import mem_ctrl_pkg::*;

	localparam int   INIT_W    = $clog2(INIT_CYCLES + 2);
	localparam int   MEM_WORDS = 1 << MEM_DEPTH_LOG2;
	localparam lat_t STALL_MAX = lat_t'(3);

	ctrl_state_t               state;
	logic [INIT_W-1:0]         init_count;
	logic [7:0]                lfsr;
	lat_t                      stall_run;
	lat_t                      lat_count;
	logic                      stall;
	logic                      cmd_accept;
	logic                      rd_accept;
	logic                      wr_accept;
	logic [MEM_DEPTH_LOG2-1:0] mem_index;
	word_t                     mem [MEM_WORDS];

	// the lfsr picks stall cycles, a run of stalls is capped at STALL_MAX
	assign stall       = (lfsr[1:0] == 2'b00) && (stall_run != STALL_MAX);
	assign o_avl_ready = (state == CTRL_READY) && !stall;

	assign cmd_accept = i_avl_burstbegin && o_avl_ready;
	assign rd_accept  = cmd_accept && i_avl_read_req;
	assign wr_accept  = cmd_accept && i_avl_write_req;
	assign mem_index  = i_avl_addr[MEM_DEPTH_LOG2-1:0]; // higher bits alias

	assign o_local_init_done = (state != CTRL_INIT);
	assign o_avl_rdata_valid = (state == CTRL_READ_PENDING) && (lat_count == '0);

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			lfsr      <= 8'hA5;
			stall_run <= '0;
		end else begin
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
			if ((state == CTRL_READY) && stall) begin
				stall_run <= stall_run + lat_t'(1);
			end else begin
				stall_run <= '0;
			end
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state      <= CTRL_INIT;
			init_count <= '0;
			lat_count  <= '0;
		end else begin
			case (state)
				CTRL_INIT: begin
					if (init_count == INIT_W'(INIT_CYCLES - 1)) begin
						state <= CTRL_READY;
					end else begin
						init_count <= init_count + 1'b1;
					end
				end
				CTRL_READY: begin
					if (rd_accept) begin
						lat_count <= lat_t'(READ_LATENCY - 1); // reaches zero READ_LATENCY cycles on
						state     <= CTRL_READ_PENDING;
					end
				end
				CTRL_READ_PENDING: begin
					if (lat_count == '0) begin
						state <= CTRL_READY;
					end else begin
						lat_count <= lat_count - lat_t'(1);
					end
				end
				default: state <= CTRL_INIT;
			endcase
		end
	end

	// word array, read word is held until the valid pulse
	always_ff @(posedge i_clock) begin
		if (wr_accept) begin
			mem[mem_index] <= i_avl_wdata;
		end
		if (rd_accept) begin
			o_avl_rdata <= mem[mem_index];
		end
	end

endmodule

// File: logic/mem_ctrl_pkg.sv
// Bridge and controller state machines
package mem_ctrl_pkg;

	typedef enum logic [1:0] {
		BRIDGE_IDLE,
		BRIDGE_ISSUE,
		BRIDGE_WAIT_DATA,
		BRIDGE_DONE
	} bridge_state_t;

	typedef enum logic [1:0] {
		CTRL_INIT,
		CTRL_READY,
		CTRL_READ_PENDING
	} ctrl_state_t;

endpackage

// File: logic/mem_request_bridge.sv
// Memory request bridge
`timescale 1ns/1ns

module mem_request_bridge (
	input  logic               i_clock,
	input  logic               i_arst_n,
	input  logic               i_request,
	input  logic               i_rw,
	input  logic [31:0]        i_address,
	input  mem_bus_pkg::word_t i_wdata,
	input  logic               i_avl_ready,
	input  logic               i_avl_rdata_valid,
	input  mem_bus_pkg::word_t i_avl_rdata,
	input  logic               i_local_init_done,
	output mem_bus_pkg::word_t o_rdata,
	output logic               o_ready,
	output logic               o_avl_read_req,
	output logic               o_avl_write_req,
	output logic               o_avl_burstbegin,
	output mem_bus_pkg::addr_t o_avl_addr,
	output mem_bus_pkg::word_t o_avl_wdata
);
	import mem_bus_pkg::*;
	import mem_ctrl_pkg::*;

	bridge_state_t state;
	logic          issue;
	logic          capture;

	assign issue   = (state == BRIDGE_IDLE) && i_request && i_local_init_done;
	assign capture = (state == BRIDGE_WAIT_DATA) && i_avl_rdata_valid;

	assign o_avl_burstbegin = o_avl_read_req | o_avl_write_req; // single beat, so every command begins a burst

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state           <= BRIDGE_IDLE;
			o_ready         <= 1'b0;
			o_avl_read_req  <= 1'b0;
			o_avl_write_req <= 1'b0;
		end else begin
			case (state)
				BRIDGE_IDLE: begin
					if (issue) begin
						o_avl_read_req  <= !i_rw;
						o_avl_write_req <= i_rw;
						state           <= BRIDGE_ISSUE;
					end
				end
				BRIDGE_ISSUE: begin
					if (i_avl_ready) begin // strobe is high here, so this is the acceptance
						o_avl_read_req  <= 1'b0;
						o_avl_write_req <= 1'b0;
						if (o_avl_write_req) begin
							o_ready <= 1'b1;
							state   <= BRIDGE_DONE;
						end else begin
							state <= BRIDGE_WAIT_DATA;
						end
					end
				end
				BRIDGE_WAIT_DATA: begin
					if (i_avl_rdata_valid) begin
						o_ready <= 1'b1; // rises together with the captured word
						state   <= BRIDGE_DONE;
					end
				end
				BRIDGE_DONE: begin
					if (!i_request) begin
						o_ready <= 1'b0;
						state   <= BRIDGE_IDLE;
					end
				end
				default: state <= BRIDGE_IDLE;
			endcase
		end
	end

	// address and data are held stable for the whole command
	always_ff @(posedge i_clock) begin
		if (issue) begin
			o_avl_addr  <= addr_t'(i_address); // upper requester bits are dropped
			o_avl_wdata <= i_wdata;
		end
		if (capture) begin
			o_rdata <= i_avl_rdata;
		end
	end

endmodule

// File: logic/mem_subsystem_top.sv
// Memory subsystem top
`timescale 1ns/1ns

module mem_subsystem_top #(
	parameter int INIT_CYCLES    = 20,
	parameter int READ_LATENCY   = 4,
	parameter int MEM_DEPTH_LOG2 = 8
) (
	input  logic               i_clock,
	input  logic               i_arst_n,
	input  logic               i_request,
	input  logic               i_rw,
	input  logic [31:0]        i_address,
	input  mem_bus_pkg::word_t i_wdata,
	output mem_bus_pkg::word_t o_rdata,
	output logic               o_ready
);
	import mem_bus_pkg::*;

	// local port between bridge and controller
	logic  avl_ready;
	logic  avl_rdata_valid;
	word_t avl_rdata;
	logic  local_init_done;
	logic  avl_read_req;
	logic  avl_write_req;
	logic  avl_burstbegin;
	addr_t avl_addr;
	word_t avl_wdata;

	mem_request_bridge bridge (
		.i_clock           (i_clock),
		.i_arst_n          (i_arst_n),
		.i_request         (i_request),
		.i_rw              (i_rw),
		.i_address         (i_address),
		.i_wdata           (i_wdata),
		.i_avl_ready       (avl_ready),
		.i_avl_rdata_valid (avl_rdata_valid),
		.i_avl_rdata       (avl_rdata),
		.i_local_init_done (local_init_done),
		.o_rdata           (o_rdata),
		.o_ready           (o_ready),
		.o_avl_read_req    (avl_read_req),
		.o_avl_write_req   (avl_write_req),
		.o_avl_burstbegin  (avl_burstbegin),
		.o_avl_addr        (avl_addr),
		.o_avl_wdata       (avl_wdata)
	);

	mem_controller_model #(
		.INIT_CYCLES    (INIT_CYCLES),
		.READ_LATENCY   (READ_LATENCY),
		.MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2)
	) controller (
		.i_clock           (i_clock),
		.i_arst_n          (i_arst_n),
		.i_avl_read_req    (avl_read_req),
		.i_avl_write_req   (avl_write_req),
		.i_avl_burstbegin  (avl_burstbegin),
		.i_avl_addr        (avl_addr),
		.i_avl_wdata       (avl_wdata),
		.o_avl_ready       (avl_ready),
		.o_avl_rdata_valid (avl_rdata_valid),
		.o_avl_rdata       (avl_rdata),
		.o_local_init_done (local_init_done)
	);

endmodule

// File: testbench/mem_subsystem_chk.sv
// Local port protocol checker
`timescale 1ns/1ns

module mem_subsystem_chk #(
	parameter int READ_LATENCY = 4
) (
	input logic i_clock,
	input logic i_arst_n,
	input logic i_avl_read_req,
	input logic i_avl_write_req,
	input logic i_avl_ready,
	input logic i_avl_rdata_valid,
	input logic i_local_init_done
);

	int assert_failures = 0;

	no_cmd_before_init: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		!i_local_init_done |-> !(i_avl_read_req || i_avl_write_req))
		else begin
			assert_failures++;
			$error("command strobe raised before local_init_done");
		end

	one_strobe_only: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		!(i_avl_read_req && i_avl_write_req))
		else begin
			assert_failures++;
			$error("read and write strobes high together");
		end

	read_held: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(i_avl_read_req && !i_avl_ready) |=> i_avl_read_req)
		else begin
			assert_failures++;
			$error("read strobe dropped before acceptance");
		end

	write_held: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(i_avl_write_req && !i_avl_ready) |=> i_avl_write_req)
		else begin
			assert_failures++;
			$error("write strobe dropped before acceptance");
		end

	// valid pulse lands exactly READ_LATENCY cycles after the accepting edge
	read_latency: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(i_avl_read_req && i_avl_ready) |-> ##READ_LATENCY i_avl_rdata_valid)
		else begin
			assert_failures++;
			$error("read data valid missing at the fixed latency");
		end

endmodule

bind mem_controller_model mem_subsystem_chk #(.READ_LATENCY(READ_LATENCY)) chk (
	.i_clock           (i_clock),
	.i_arst_n          (i_arst_n),
	.i_avl_read_req    (i_avl_read_req),
	.i_avl_write_req   (i_avl_write_req),
	.i_avl_ready       (o_avl_ready),
	.i_avl_rdata_valid (o_avl_rdata_valid),
	.i_local_init_done (o_local_init_done)
);

// File: testbench/mem_subsystem_tb.sv
// Memory subsystem testbench
`timescale 1ns/1ns

module mem_subsystem_tb;
	import mem_bus_pkg::*;

	localparam int          CLK_PERIOD     = 8;
	localparam int          MEM_DEPTH_LOG2 = 8; // same as the top level default
	localparam int          TIMEOUT_CYCLES = 100;
	localparam int          MIX_REQUESTS   = 300;
	localparam logic [31:0] SEED           = 32'h30a4_f8ff;

	logic        i_clock;
	logic        i_arst_n;
	logic        i_request;
	logic        i_rw;
	logic [31:0] i_address;
	word_t       i_wdata;
	word_t       o_rdata;
	logic        o_ready;

	word_t       ref_mem [int]; // words as the memory should hold them
	logic [31:0] written_addrs[$];
	int          mismatch_count;
	int          timeout_count;

	mem_subsystem_top uut (
		.i_clock   (i_clock),
		.i_arst_n  (i_arst_n),
		.i_request (i_request),
		.i_rw      (i_rw),
		.i_address (i_address),
		.i_wdata   (i_wdata),
		.o_rdata   (o_rdata),
		.o_ready   (o_ready)
	);

	initial begin
		i_clock = 1'b0;
		forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
	end

	// only the low address bits select a stored word, the rest alias
	function automatic int model_index(input logic [31:0] addr);
		return int'(addr[MEM_DEPTH_LOG2-1:0]);
	endfunction

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_ready(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch %s ready: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic wait_ready(input string name, input logic level, output logic ok);
		int waited;
		waited = 0;
		while (o_ready !== level && waited < TIMEOUT_CYCLES) begin
			@(negedge i_clock);
			waited++;
		end
		ok = (o_ready === level);
		if (!ok) begin
			timeout_count++;
			$display("timeout in %s: ready did not go %s within %0d cycles",
				name, level ? "high" : "low", TIMEOUT_CYCLES);
		end
	endtask

	// starts and ends right after a falling edge
	task automatic run_request(input string name, input logic rw, input logic [31:0] addr,
			input word_t wdata, input int hold_extra);
		logic ok;
		int   idx;
		idx       = model_index(addr);
		i_request = 1'b1;
		i_rw      = rw;
		i_address = addr;
		i_wdata   = wdata;
		@(negedge i_clock);
		check_ready(name, 1'b0, o_ready); // no command can finish this early
		wait_ready(name, 1'b1, ok);
		if (ok) begin
			if (rw) begin
				ref_mem[idx] = wdata;
				written_addrs.push_back(addr);
			end else begin
				check_word(name, ref_mem[idx], o_rdata);
			end
			repeat (hold_extra) begin
				@(negedge i_clock);
				check_ready(name, 1'b1, o_ready); // stays up while the request is held
			end
		end
		i_request = 1'b0;
		i_rw      = 1'b0;
		@(negedge i_clock);
		check_ready(name, 1'b0, o_ready);
		wait_ready(name, 1'b0, ok);
	endtask

	initial begin
		logic [31:0] addr;
		logic [31:0] alias_addr;
		word_t       data;
		logic        rw;

		void'($urandom(SEED));
		mismatch_count = 0;
		timeout_count  = 0;
		i_arst_n       = 1'b0;
		i_request      = 1'b0;
		i_rw           = 1'b0;
		i_address      = '0;
		i_wdata        = '0;

		repeat (3) begin
			@(negedge i_clock);
			check_ready("reset", 1'b0, o_ready);
		end
		i_arst_n = 1'b1;

		// raised while the controller is still initialising
		addr = $urandom();
		data = $urandom();
		run_request("early_write", 1'b1, addr, data, 0);
		run_request("early_read", 1'b0, addr, $urandom(), 0);

		for (int i = 0; i < 8; i++) begin
			addr = $urandom();
			data = $urandom();
			run_request("write_read", 1'b1, addr, data, 0);
			run_request("write_read", 1'b0, addr, $urandom(), 0);
		end

		for (int i = 0; i < 4; i++) begin
			addr       = $urandom();
			alias_addr = addr ^ (32'($urandom_range(255, 1)) << MEM_DEPTH_LOG2);
			run_request("alias_first", 1'b1, addr, $urandom(), 0);
			run_request("alias_second", 1'b1, alias_addr, $urandom(), 0);
			run_request("alias_read_a", 1'b0, addr, $urandom(), 0);
			run_request("alias_read_b", 1'b0, alias_addr, $urandom(), 0);
		end

		for (int i = 0; i < MIX_REQUESTS; i++) begin
			rw = $urandom_range(1, 0) == 1;
			if (rw) begin
				addr = $urandom();
			end else begin
				addr = written_addrs[$urandom_range(written_addrs.size() - 1, 0)];
			end
			run_request("random_mix", rw, addr, $urandom(), $urandom_range(3, 0));
		end

		for (int i = 0; i < 6; i++) begin
			addr = written_addrs[$urandom_range(written_addrs.size() - 1, 0)];
			run_request("ready_hold", 1'b0, addr, $urandom(), $urandom_range(8, 2));
		end

		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatch_count, timeout_count, uut.controller.chk.assert_failures);
		if (mismatch_count == 0 && timeout_count == 0
				&& uut.controller.chk.assert_failures == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
